//--- apb_delay_checker.sv
`timescale 1ns/100ps

module apb_delay_checker (
    input  logic                 clock,
    input  logic                 reset,
    input  apb_delay_pkg::addr_t paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  apb_delay_pkg::prot_t pprot,
    input  logic                 pwrite,
    input  apb_delay_pkg::data_t pwdata,
    input  apb_delay_pkg::strb_t pstrb,
    input  logic                 pready,
    input  apb_delay_pkg::data_t prdata,
    input  logic                 pslverr,
    output int                   error_count,
    output int                   transfer_count
);

    apb_delay_pkg::data_t model_mem [apb_delay_pkg::mem_words];
    apb_delay_pkg::data_t exp_rdata;
    apb_delay_pkg::data_t new_word;
    logic                 exp_err;
    int                   exp_latency;
    logic [3:0]           word;
    logic                 in_transfer;
    int                   access_cycles;

    // expected outcome of one transfer, worked out from the memory map.
    function automatic void reference_access(
        input  apb_delay_pkg::addr_t addr,
        input  apb_delay_pkg::data_t wdata,
        input  apb_delay_pkg::strb_t strb,
        input  apb_delay_pkg::prot_t prot,
        input  logic                 write,
        input  apb_delay_pkg::data_t old_word,
        output apb_delay_pkg::data_t rdata,
        output logic                 err,
        output apb_delay_pkg::data_t updated,
        output int                   latency
    );
        logic in_range;
        int   wait_states;
        in_range    = addr < apb_delay_pkg::mem_words * 4;
        wait_states = addr[5:4];
        // peripheral waits W and is ready once, then the delayer adds ratio times W.
        latency = (wait_states + 1) + apb_delay_pkg::delay_ratio * wait_states + 1;
        err     = !in_range ||
                  (write && !prot[0] && addr[5:2] >= apb_delay_pkg::protected_first_word);
        updated = old_word;
        rdata   = '0;
        if (write && !err) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    updated[8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        if (!write && in_range) begin
            rdata = old_word;
        end
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h at %0t",
                 name, expected, actual, $time);
        error_count++;
    endtask

    always @(posedge clock) begin
        if (reset) begin
            in_transfer   = 1'b0;
            access_cycles = 0;
        end else if (psel && !penable) begin
            word = paddr[5:2];
            reference_access(paddr, pwdata, pstrb, pprot, pwrite, model_mem[word],
                             exp_rdata, exp_err, new_word, exp_latency);
            in_transfer   = 1'b1;
            access_cycles = 0;
        end else if (psel && penable && in_transfer) begin
            access_cycles++;
            if (pready) begin
                if (access_cycles != exp_latency) begin
                    report_value("pready latency", exp_latency, access_cycles);
                end
                if (prdata !== exp_rdata) begin
                    report_value("prdata", exp_rdata, prdata);
                end
                if (pslverr !== exp_err) begin
                    report_value("pslverr", exp_err, pslverr);
                end
                model_mem[word] = new_word;
                in_transfer     = 1'b0;
                transfer_count++;
            end
        end else if (pready) begin
            $display("pready came without a transfer in its access phase at %0t", $time);
            error_count++;
        end
    end

endmodule

//--- apb_delay_pkg.sv
package apb_delay_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  prot_t;

    // wide enough for the scaled sum of the longest wait.
    typedef logic [23:0] delay_count_t;

    // response delay is delay_ratio times the peripheral wait count.
    localparam int delay_ratio     = 2;
    localparam int delay_frac_bits = 10;

    // amount added per wait cycle, in fixed point.
    localparam delay_count_t delay_step = delay_count_t'(delay_ratio << delay_frac_bits);

    localparam int    mem_words = 16;
    localparam int    word_bits = $clog2(mem_words);
    localparam addr_t mem_bytes = addr_t'(mem_words * 4);

    // words from this index up accept privileged writes only.
    localparam int protected_first_word = 12;

    // the wait state count sits in these two address bits.
    localparam int wait_lsb = 4;

    typedef enum logic [1:0] {
        idle,
        active,
        delay
    } delayer_state_t;

endpackage

//--- apb_delay_properties.sv
`timescale 1ns/100ps

module apb_delay_properties (
    input logic                 clock,
    input logic                 reset,
    input logic                 in_psel,
    input logic                 in_penable,
    input logic                 in_pready,
    input apb_delay_pkg::data_t in_prdata
);

    // a transfer completes in exactly one cycle.
    single_ready_cycle: assert property (
        @(posedge clock) disable iff (reset) in_pready |=> !in_pready
    ) else $error("pready stayed high for two cycles");

    quiet_read_data: assert property (
        @(posedge clock) disable iff (reset) !in_pready |-> (in_prdata == '0)
    ) else $error("prdata not zero outside the ready cycle");

    // the response may only land in an access phase.
    ready_in_access: assert property (
        @(posedge clock) disable iff (reset) in_pready |-> (in_psel && in_penable)
    ) else $error("pready high outside an access phase");

endmodule

bind apb_delayer apb_delay_properties delayer_properties_i (
    .clock      (clock),
    .reset      (reset),
    .in_psel    (in_psel),
    .in_penable (in_penable),
    .in_pready  (in_pready),
    .in_prdata  (in_prdata)
);

//--- apb_delay_system.sv
`timescale 1ns/100ps

module apb_delay_system (
    input  logic                 clock,
    input  logic                 reset,
    input  apb_delay_pkg::addr_t paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  apb_delay_pkg::prot_t pprot,
    input  logic                 pwrite,
    input  apb_delay_pkg::data_t pwdata,
    input  apb_delay_pkg::strb_t pstrb,
    output logic                 pready,
    output apb_delay_pkg::data_t prdata,
    output logic                 pslverr
);

    // bus between the delayer and the peripheral.
    apb_if periph_bus ();

    apb_delayer delayer_i (
        .clock      (clock),
        .reset      (reset),
        .in_paddr   (paddr),
        .in_psel    (psel),
        .in_penable (penable),
        .in_pprot   (pprot),
        .in_pwrite  (pwrite),
        .in_pwdata  (pwdata),
        .in_pstrb   (pstrb),
        .in_pready  (pready),
        .in_prdata  (prdata),
        .in_pslverr (pslverr),
        .out_bus    (periph_bus)
    );

    apb_wait_memory memory_i (
        .clock (clock),
        .reset (reset),
        .bus   (periph_bus)
    );

endmodule

//--- apb_delay_tb.sv
`timescale 1ns/100ps

module apb_delay_tb;

    localparam int clock_period        = 40;
    localparam int reset_cycles        = 3;
    localparam int random_transfers    = 40;
    localparam int total_transfers     = 54 + random_transfers;
    localparam int cycles_per_transfer = 15;
    localparam int timeout_cycles      = total_transfers * cycles_per_transfer + 100;

    logic                 clock;
    logic                 reset;
    apb_delay_pkg::addr_t paddr;
    logic                 psel;
    logic                 penable;
    apb_delay_pkg::prot_t pprot;
    logic                 pwrite;
    apb_delay_pkg::data_t pwdata;
    apb_delay_pkg::strb_t pstrb;
    logic                 pready;
    apb_delay_pkg::data_t prdata;
    logic                 pslverr;
    int                   checker_errors;
    int                   checked_transfers;
    int                   cycle_count;

    apb_delay_system dut_i (
        .clock   (clock),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pprot   (pprot),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    apb_delay_checker checker_i (
        .clock          (clock),
        .reset          (reset),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pprot          (pprot),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .pstrb          (pstrb),
        .pready         (pready),
        .prdata         (prdata),
        .pslverr        (pslverr),
        .error_count    (checker_errors),
        .transfer_count (checked_transfers)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // returns at the rising edge where pready is sampled high.
    task automatic apb_transfer(input apb_delay_pkg::addr_t addr, input apb_delay_pkg::data_t data,
                                input apb_delay_pkg::strb_t strb, input apb_delay_pkg::prot_t prot,
                                input logic write);
        @(negedge clock);
        paddr   = addr;
        pwdata  = data;
        pstrb   = write ? strb : '0;
        pprot   = prot;
        pwrite  = write;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clock);
        penable = 1'b1;
        @(posedge clock);
        while (!pready) begin
            @(posedge clock);
        end
    endtask

    task automatic apb_write(input apb_delay_pkg::addr_t addr, input apb_delay_pkg::strb_t strb,
                             input apb_delay_pkg::prot_t prot);
        apb_transfer(addr, apb_delay_pkg::data_t'($urandom), strb, prot, 1'b1);
    endtask

    task automatic apb_read(input apb_delay_pkg::addr_t addr);
        apb_transfer(addr, '0, '0, 3'b000, 1'b0);
    endtask

    task automatic bus_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("run stopped after %0d cycles with transfers still outstanding", cycle_count);
        $display("errors: %0d checker, 1 timeout", checker_errors);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h4a2e9773));
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pprot   = '0;
        pwrite  = 1'b0;
        pwdata  = '0;
        pstrb   = '0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        bus_idle(2);

        // words 0 to 15 cover every wait count from 0 to 3.
        for (int i = 0; i < 16; i++) begin
            apb_write(apb_delay_pkg::addr_t'(i * 4), 4'hf, 3'b001);
        end
        for (int i = 0; i < 16; i++) begin
            apb_read(apb_delay_pkg::addr_t'(i * 4));
        end
        bus_idle(2);

        apb_write(32'h04, 4'b0001, 3'b000);
        apb_write(32'h14, 4'b0110, 3'b000);
        apb_write(32'h24, 4'b1000, 3'b000);
        apb_write(32'h28, 4'b0101, 3'b000);
        apb_read(32'h04);
        apb_read(32'h14);
        apb_read(32'h24);
        apb_read(32'h28);

        for (int i = 12; i < 16; i++) begin
            apb_write(apb_delay_pkg::addr_t'(i * 4), 4'hf, 3'b000);
        end
        for (int i = 12; i < 16; i++) begin
            apb_read(apb_delay_pkg::addr_t'(i * 4));
        end
        apb_write(32'h34, 4'hf, 3'b011);
        apb_read(32'h34);

        apb_write(32'h40, 4'hf, 3'b001);
        apb_read(32'h44);
        apb_write(32'h7c, 4'hf, 3'b001);
        apb_read(32'hffff_fff0);
        bus_idle(2);

        // about a third of these addresses fall outside the memory.
        repeat (random_transfers) begin
            apb_transfer(apb_delay_pkg::addr_t'($urandom_range(23, 0) << 2),
                         apb_delay_pkg::data_t'($urandom), apb_delay_pkg::strb_t'($urandom),
                         apb_delay_pkg::prot_t'($urandom), 1'($urandom_range(1, 0)));
        end
        bus_idle(4);

        $display("errors: %0d checker; %0d transfers checked",
                 checker_errors, checked_transfers);
        if (checker_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- apb_delayer.sv
`timescale 1ns/100ps

module apb_delayer (
    input  logic                 clock,
    input  logic                 reset,
    input  apb_delay_pkg::addr_t in_paddr,
    input  logic                 in_psel,
    input  logic                 in_penable,
    input  apb_delay_pkg::prot_t in_pprot,
    input  logic                 in_pwrite,
    input  apb_delay_pkg::data_t in_pwdata,
    input  apb_delay_pkg::strb_t in_pstrb,
    output logic                 in_pready,
    output apb_delay_pkg::data_t in_prdata,
    output logic                 in_pslverr,
    apb_if.requester             out_bus
);

    apb_delay_pkg::delayer_state_t state;
    apb_delay_pkg::delay_count_t   delay_count;
    apb_delay_pkg::delay_count_t   scaled_count;
    apb_delay_pkg::data_t          held_prdata;
    logic                          held_pslverr;
    logic                          setup_phase;
    logic                          periph_done;
    logic                          response_due;

    // the request side is not delayed at all.
    assign out_bus.paddr   = in_paddr;
    assign out_bus.psel    = in_psel;
    assign out_bus.penable = in_penable;
    assign out_bus.pprot   = in_pprot;
    assign out_bus.pwrite  = in_pwrite;
    assign out_bus.pwdata  = in_pwdata;
    assign out_bus.pstrb   = in_pstrb;

    assign setup_phase  = in_psel && !in_penable;
    assign periph_done  = (state == apb_delay_pkg::active) && out_bus.pready;
    assign scaled_count = delay_count >> apb_delay_pkg::delay_frac_bits;

    // the response register is loaded one cycle before the countdown ends,
    // so that the requester sees pready in access cycle 3W + 2.
    assign response_due = (periph_done && scaled_count == '0) ||
                          (state == apb_delay_pkg::delay &&
                           delay_count == apb_delay_pkg::delay_count_t'(1));

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= apb_delay_pkg::idle;
        end else if (setup_phase) begin
            state <= apb_delay_pkg::active;
        end else if (periph_done) begin
            state <= apb_delay_pkg::delay;
        end else if (state == apb_delay_pkg::delay && delay_count == '0) begin
            state <= apb_delay_pkg::idle;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            delay_count <= '0;
        end else if (setup_phase) begin
            delay_count <= '0;
        end else if (state == apb_delay_pkg::active) begin
            if (out_bus.pready) begin
                delay_count <= scaled_count;
            end else begin
                delay_count <= delay_count + apb_delay_pkg::delay_step;
            end
        end else if (state == apb_delay_pkg::delay && delay_count != '0) begin
            delay_count <= delay_count - apb_delay_pkg::delay_count_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (periph_done) begin
            held_prdata  <= out_bus.prdata;
            held_pslverr <= out_bus.pslverr;
        end
    end

    // with no wait the response comes straight from the peripheral.
    always_ff @(posedge clock) begin
        if (reset) begin
            in_pready  <= 1'b0;
            in_prdata  <= '0;
            in_pslverr <= 1'b0;
        end else if (response_due) begin
            in_pready  <= 1'b1;
            in_prdata  <= periph_done ? out_bus.prdata : held_prdata;
            in_pslverr <= periph_done ? out_bus.pslverr : held_pslverr;
        end else begin
            in_pready  <= 1'b0;
            in_prdata  <= '0;
            in_pslverr <= 1'b0;
        end
    end

endmodule

//--- apb_if.sv
`timescale 1ns/100ps

interface apb_if;

    apb_delay_pkg::addr_t paddr;
    logic                 psel;
    logic                 penable;
    apb_delay_pkg::prot_t pprot;
    logic                 pwrite;
    apb_delay_pkg::data_t pwdata;
    apb_delay_pkg::strb_t pstrb;
    logic                 pready;
    apb_delay_pkg::data_t prdata;
    logic                 pslverr;

    modport requester (
        output paddr,
        output psel,
        output penable,
        output pprot,
        output pwrite,
        output pwdata,
        output pstrb,
        input  pready,
        input  prdata,
        input  pslverr
    );

    modport completer (
        input  paddr,
        input  psel,
        input  penable,
        input  pprot,
        input  pwrite,
        input  pwdata,
        input  pstrb,
        output pready,
        output prdata,
        output pslverr
    );

endinterface

//--- apb_wait_memory.sv
`timescale 1ns/100ps

module apb_wait_memory (
    input  logic      clock,
    input  logic      reset,
    apb_if.completer  bus
);

    apb_delay_pkg::data_t                mem [apb_delay_pkg::mem_words];
    logic [1:0]                          wait_count;
    logic                                pending;
    logic                                setup_phase;
    logic                                access_ready;
    logic                                addr_error;
    logic                                prot_error;
    logic                                slv_error;
    logic [apb_delay_pkg::word_bits-1:0] word_index;

    assign setup_phase = bus.psel && !bus.penable;
    assign word_index  = bus.paddr[apb_delay_pkg::word_bits+1:2];

    assign addr_error = bus.paddr >= apb_delay_pkg::mem_bytes;
    assign prot_error = bus.pwrite && !bus.pprot[0] &&
                        (word_index >= apb_delay_pkg::protected_first_word);
    assign slv_error  = addr_error || prot_error;

    // ready comes once per transfer, after the wait count has run out.
    assign access_ready = pending && bus.psel && bus.penable && (wait_count == 2'd0);

    always_ff @(posedge clock) begin
        if (reset) begin
            pending    <= 1'b0;
            wait_count <= 2'd0;
        end else if (setup_phase) begin
            pending    <= 1'b1;
            wait_count <= bus.paddr[apb_delay_pkg::wait_lsb +: 2];
        end else if (pending && bus.psel && bus.penable) begin
            if (wait_count == 2'd0) begin
                pending <= 1'b0;
            end else begin
                wait_count <= wait_count - 2'd1;
            end
        end
    end

    // erroneous writes leave the memory untouched.
    always_ff @(posedge clock) begin
        if (access_ready && bus.pwrite && !slv_error) begin
            for (int b = 0; b < $bits(apb_delay_pkg::strb_t); b++) begin
                if (bus.pstrb[b]) begin
                    mem[word_index][8*b +: 8] <= bus.pwdata[8*b +: 8];
                end
            end
        end
    end

    assign bus.pready  = access_ready;
    assign bus.pslverr = access_ready && slv_error;

    // read data is zero outside the ready cycle and for unmapped addresses.
    assign bus.prdata = (access_ready && !bus.pwrite && !addr_error) ?
                        mem[word_index] : '0;

endmodule

//--- list.f
apb_delay_pkg.sv
apb_if.sv
apb_delayer.sv
apb_wait_memory.sv
apb_delay_system.sv
apb_delay_properties.sv
apb_delay_checker.sv
apb_delay_tb.sv
